//--- rv32_defines.svh
`ifndef RV32_DEFINES_SVH
`define RV32_DEFINES_SVH

// memory access width codes, code 3 is illegal
`define RV32_MEM_WIDTH_WORD 2'd0
`define RV32_MEM_WIDTH_HALF 2'd1
`define RV32_MEM_WIDTH_BYTE 2'd2

// branch condition, evaluated against the alu zero flag
`define RV32_BRANCH_OP_NEVER    2'd0
`define RV32_BRANCH_OP_ZERO     2'd1
`define RV32_BRANCH_OP_NON_ZERO 2'd2
`define RV32_BRANCH_OP_ALWAYS   2'd3

// data ram geometry
`define RV32_DRAM_WORDS     256
`define RV32_DRAM_ADDR_BITS 8  // word index width

`endif

//--- rv32_pkg.sv
`default_nettype none

package rv32_pkg;

    // one memory word, seen either as byte lanes or as halves
    typedef union packed {
        logic [3:0][7:0]  bytes;   // indexed by address bits 1:0
        logic [1:0][15:0] halves;  // indexed by address bit 1
    } mem_word_u;

endpackage

`default_nettype wire

//--- rv32_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32_defines.svh"

module rv32_branch_unit (
    input  logic       predicted_taken,
    input  logic       alu_non_zero,
    input  logic [1:0] op,
    output logic       mispredicted
);

    logic taken;

    always_comb begin
        case (op)
            `RV32_BRANCH_OP_NEVER:    taken = 1'b0;
            `RV32_BRANCH_OP_ZERO:     taken = !alu_non_zero;
            `RV32_BRANCH_OP_NON_ZERO: taken = alu_non_zero;
            `RV32_BRANCH_OP_ALWAYS:   taken = 1'b1;
            default:                  taken = 1'b0;
        endcase
    end

    assign mispredicted = taken != predicted_taken;  // raw, not yet qualified

endmodule

`default_nettype wire

//--- rv32_store_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32_defines.svh"

module rv32_store_align (
    input  logic [1:0]          address_low,
    input  logic [1:0]          width,
    input  logic [31:0]         store_value,
    output rv32_pkg::mem_word_u lane_value,
    output logic [3:0]          byte_mask
);

    always_comb begin
        lane_value = store_value;
        byte_mask = 4'b0000;
        case (width)
            `RV32_MEM_WIDTH_WORD: begin
                byte_mask = 4'b1111;
            end
            `RV32_MEM_WIDTH_HALF: begin
                lane_value.halves = {2{store_value[15:0]}};  // both halves carry it
                byte_mask = address_low[1] ? 4'b1100 : 4'b0011;
            end
            `RV32_MEM_WIDTH_BYTE: begin
                lane_value.bytes = {4{store_value[7:0]}};
                byte_mask = 4'b0001 << address_low;
            end
            default: begin
                byte_mask = 4'b0000;  // illegal code writes nothing
            end
        endcase
    end

    // only meaningful while a store is presented, the stage parks width at word otherwise
    always_comb begin
        a_half_aligned: assert final (!(width == `RV32_MEM_WIDTH_HALF && address_low[0]))
            else $error("store_align: halfword store at odd address");
        a_width_legal: assert final (width != 2'd3)
            else $error("store_align: illegal width code");
    end

endmodule

`default_nettype wire

//--- rv32_load_extract.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32_defines.svh"

module rv32_load_extract (
    input  logic [1:0]          address_low,
    input  logic [1:0]          width,
    input  logic                zero_extend,
    input  rv32_pkg::mem_word_u read_word,
    output logic [31:0]         load_value
);

    logic [15:0] sel_half;
    logic [7:0]  sel_byte;
    logic        fill;  // bit copied into the upper part

    assign sel_half = read_word.halves[address_low[1]];
    assign sel_byte = read_word.bytes[address_low];

    always_comb begin
        fill = 1'b0;
        case (width)
            `RV32_MEM_WIDTH_HALF: begin
                fill = !zero_extend && sel_half[15];
                load_value = {{16{fill}}, sel_half};
            end
            `RV32_MEM_WIDTH_BYTE: begin
                fill = !zero_extend && sel_byte[7];
                load_value = {{24{fill}}, sel_byte};
            end
            default: begin
                load_value = read_word;  // word loads pass through
            end
        endcase
    end

    always_comb begin
        a_half_aligned: assert final (!(width == `RV32_MEM_WIDTH_HALF && address_low[0]))
            else $error("load_extract: halfword load at odd address");
    end

endmodule

`default_nettype wire

//--- rv32_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32_defines.svh"

module rv32_mem (
    input  logic                clk,
    input  logic                reset_,
    input  logic                stall,
    input  logic                flush,
    input  logic                valid,
    input  logic                branch_predicted_taken,
    input  logic                alu_non_zero,
    input  logic                read,
    input  logic                write,
    input  logic [1:0]          width,
    input  logic                zero_extend,
    input  logic [1:0]          branch_op,
    input  logic [4:0]          rd,
    input  logic                rd_write,
    input  logic [31:0]         result,
    input  logic [31:0]         rs2_value,
    input  logic [31:0]         branch_pc,
    input  rv32_pkg::mem_word_u data_read_value,
    output logic                branch_mispredicted,
    output logic [31:0]         redirect_pc,
    output logic                data_read,
    output logic                data_write,
    output logic [3:0]          data_write_mask,
    output logic [31:0]         data_address,
    output rv32_pkg::mem_word_u data_write_value,
    output logic                wb_valid,
    output logic [4:0]          wb_rd,
    output logic                wb_rd_write,
    output logic [31:0]         wb_rd_value
);

    logic        raw_mispredict;
    logic        mem_go;  // instruction actually leaves the stage this cycle
    logic [1:0]  store_width;
    logic [1:0]  load_width;
    logic [3:0]  lane_mask;
    logic [31:0] load_value;

    rv32_branch_unit branch_unit_inst (
        .predicted_taken (branch_predicted_taken),
        .alu_non_zero    (alu_non_zero),
        .op              (branch_op),
        .mispredicted    (raw_mispredict)
    );

    assign branch_mispredicted = valid && !flush && raw_mispredict;
    assign redirect_pc = branch_pc;

    assign mem_go = valid && !stall && !flush;
    assign data_read = mem_go && read;
    assign data_write = mem_go && write;
    assign data_address = result;

    // width only matters while the matching access is requested
    assign store_width = write ? width : `RV32_MEM_WIDTH_WORD;
    assign load_width = read ? width : `RV32_MEM_WIDTH_WORD;

    rv32_store_align store_align_inst (
        .address_low (result[1:0]),
        .width       (store_width),
        .store_value (rs2_value),
        .lane_value  (data_write_value),
        .byte_mask   (lane_mask)
    );

    assign data_write_mask = data_write ? lane_mask : 4'b0000;

    rv32_load_extract load_extract_inst (
        .address_low (result[1:0]),
        .width       (load_width),
        .zero_extend (zero_extend),
        .read_word   (data_read_value),
        .load_value  (load_value)
    );

    always_ff @(posedge clk) begin
        if (!reset_) begin
            wb_valid <= 1'b0;
            wb_rd <= 5'd0;
            wb_rd_write <= 1'b0;
            wb_rd_value <= 32'd0;
        end else if (!stall) begin  // stall holds the register
            wb_valid <= valid && !flush;
            wb_rd <= rd;
            wb_rd_write <= rd_write && !flush;
            wb_rd_value <= read ? load_value : result;
        end
    end

    a_no_read_write: assert property (@(posedge clk) disable iff (!reset_)
        !(read && write))
        else $error("rv32_mem: read and write high together");

endmodule

`default_nettype wire

//--- rv32_data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32_defines.svh"

module rv32_data_ram (
    input  logic                clk,
    input  logic                read,
    input  logic                write,
    input  logic [3:0]          write_mask,
    input  logic [31:0]         address,
    input  rv32_pkg::mem_word_u write_value,
    output rv32_pkg::mem_word_u read_value
);

    import rv32_pkg::*;

    mem_word_u                       mem [`RV32_DRAM_WORDS];
    logic [`RV32_DRAM_ADDR_BITS-1:0] index;

    assign index = address[`RV32_DRAM_ADDR_BITS+1:2];  // upper bits ignored, wraps
    assign read_value = mem[index];

    initial begin
        for (int i = 0; i < `RV32_DRAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (write_mask[lane]) begin
                    mem[index].bytes[lane] <= write_value.bytes[lane];
                end
            end
        end
    end

    a_read_addr_known: assert property (@(posedge clk) read |-> !$isunknown(address))
        else $error("data_ram: read with unknown address");

endmodule

`default_nettype wire

//--- rv32_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module rv32_mem_subsys (
    input  logic        clk,
    input  logic        reset_,
    input  logic        valid,
    input  logic        read,
    input  logic        write,
    input  logic [1:0]  width,
    input  logic        zero_extend,
    input  logic [1:0]  branch_op,
    input  logic        branch_predicted_taken,
    input  logic        alu_non_zero,
    input  logic [4:0]  rd,
    input  logic        rd_write,
    input  logic [31:0] result,
    input  logic [31:0] rs2_value,
    input  logic [31:0] branch_pc,
    input  logic        stall,
    input  logic        flush,
    output logic        branch_mispredicted,
    output logic [31:0] redirect_pc,
    output logic        wb_valid,
    output logic [4:0]  wb_rd,
    output logic        wb_rd_write,
    output logic [31:0] wb_rd_value
);

    import rv32_pkg::*;

    logic        data_read;
    logic        data_write;
    logic [3:0]  data_write_mask;
    logic [31:0] data_address;
    mem_word_u   data_write_value;
    mem_word_u   data_read_value;

    rv32_mem rv32_mem_inst (
        .clk                    (clk),
        .reset_                 (reset_),
        .stall                  (stall),
        .flush                  (flush),
        .valid                  (valid),
        .branch_predicted_taken (branch_predicted_taken),
        .alu_non_zero           (alu_non_zero),
        .read                   (read),
        .write                  (write),
        .width                  (width),
        .zero_extend            (zero_extend),
        .branch_op              (branch_op),
        .rd                     (rd),
        .rd_write               (rd_write),
        .result                 (result),
        .rs2_value              (rs2_value),
        .branch_pc              (branch_pc),
        .data_read_value        (data_read_value),
        .branch_mispredicted    (branch_mispredicted),
        .redirect_pc            (redirect_pc),
        .data_read              (data_read),
        .data_write             (data_write),
        .data_write_mask        (data_write_mask),
        .data_address           (data_address),
        .data_write_value       (data_write_value),
        .wb_valid               (wb_valid),
        .wb_rd                  (wb_rd),
        .wb_rd_write            (wb_rd_write),
        .wb_rd_value            (wb_rd_value)
    );

    rv32_data_ram rv32_data_ram_inst (
        .clk         (clk),
        .read        (data_read),
        .write       (data_write),
        .write_mask  (data_write_mask),
        .address     (data_address),
        .write_value (data_write_value),
        .read_value  (data_read_value)
    );

endmodule

`default_nettype wire

//--- rv32_mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32_defines.svh"

module rv32_mem_subsys_tb;

    import rv32_pkg::*;

    localparam int N_WORD = 300;
    localparam int N_PART = 300;
    localparam int N_EXT = 300;
    localparam int N_ALU = 300;
    localparam int N_BR = 300;
    localparam int N_HAZ = 400;
    localparam int RESET_CYCLES = 3;
    localparam int STIM_CYCLES = RESET_CYCLES + 2 * N_WORD + 3 * N_PART + N_EXT + N_ALU
                                 + N_BR + N_HAZ + `RV32_DRAM_WORDS;
    localparam int MAX_CYCLES = STIM_CYCLES + 100;

    logic        clk = 1'b0;
    logic        reset_;
    logic        valid;
    logic        read;
    logic        write;
    logic [1:0]  width;
    logic        zero_extend;
    logic [1:0]  branch_op;
    logic        branch_predicted_taken;
    logic        alu_non_zero;
    logic [4:0]  rd;
    logic        rd_write;
    logic [31:0] result;
    logic [31:0] rs2_value;
    logic [31:0] branch_pc;
    logic        stall;
    logic        flush;
    logic        branch_mispredicted;
    logic [31:0] redirect_pc;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic        wb_rd_write;
    logic [31:0] wb_rd_value;

    integer      seed = 32'h23b8a65d;
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          test_errors_at_start;
    string       test_name;

    mem_word_u   shadow [`RV32_DRAM_WORDS];  // reference copy of the ram
    logic        exp_wb_valid;
    logic [4:0]  exp_wb_rd;
    logic        exp_wb_rd_write;
    mem_word_u   exp_wb_value;
    logic [31:0] addr_q [$];

    rv32_mem_subsys rv32_mem_subsys_inst (
        .clk                    (clk),
        .reset_                 (reset_),
        .valid                  (valid),
        .read                   (read),
        .write                  (write),
        .width                  (width),
        .zero_extend            (zero_extend),
        .branch_op              (branch_op),
        .branch_predicted_taken (branch_predicted_taken),
        .alu_non_zero           (alu_non_zero),
        .rd                     (rd),
        .rd_write               (rd_write),
        .result                 (result),
        .rs2_value              (rs2_value),
        .branch_pc              (branch_pc),
        .stall                  (stall),
        .flush                  (flush),
        .branch_mispredicted    (branch_mispredicted),
        .redirect_pc            (redirect_pc),
        .wb_valid               (wb_valid),
        .wb_rd                  (wb_rd),
        .wb_rd_write            (wb_rd_write),
        .wb_rd_value            (wb_rd_value)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: simulation ran %0d cycles without finishing the tests",
                     cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    function automatic logic [1:0] rand_width();
        logic [31:0] r;
        r = rand32();
        rand_width = (r[1:0] == 2'd3) ? `RV32_MEM_WIDTH_WORD : r[1:0];
    endfunction

    // aligned address inside the ram for the given width
    function automatic logic [31:0] rand_addr(logic [1:0] wd);
        logic [31:0] r;
        logic [1:0]  low;
        r = rand32();
        case (wd)
            `RV32_MEM_WIDTH_HALF: low = {r[9], 1'b0};
            `RV32_MEM_WIDTH_BYTE: low = r[9:8];
            default:              low = 2'b00;
        endcase
        rand_addr = {22'd0, r[7:0], low};
    endfunction

    function automatic logic [31:0] extend_load(mem_word_u w, logic [1:0] low,
                                                logic [1:0] wd, logic zx);
        logic [7:0]  b;
        logic [15:0] h;
        b = w.bytes[low];
        h = w.halves[low[1]];
        case (wd)
            `RV32_MEM_WIDTH_HALF: extend_load = zx ? {16'd0, h} : {{16{h[15]}}, h};
            `RV32_MEM_WIDTH_BYTE: extend_load = zx ? {24'd0, b} : {{24{b[7]}}, b};
            default:              extend_load = w;
        endcase
    endfunction

    function automatic mem_word_u merge_store(mem_word_u old, logic [1:0] low,
                                              logic [1:0] wd, logic [31:0] v);
        merge_store = old;
        case (wd)
            `RV32_MEM_WIDTH_WORD: merge_store = v;
            `RV32_MEM_WIDTH_HALF: merge_store.halves[low[1]] = v[15:0];
            `RV32_MEM_WIDTH_BYTE: merge_store.bytes[low] = v[7:0];
            default:              merge_store = old;  // illegal code stores nothing
        endcase
    endfunction

    task automatic check_word(string what, mem_word_u exp, mem_word_u act);
        check_count++;
        if (act !== exp) begin
            $display("ERROR %s: %s expected %h actual %h", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        check_count++;
        if (act !== exp) begin
            $display("ERROR %s: %s expected %b actual %b", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_rd(string what, logic [4:0] exp, logic [4:0] act);
        check_count++;
        if (act !== exp) begin
            $display("ERROR %s: %s expected %0d actual %0d", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_errors_at_start = error_count;
    endtask

    task automatic end_test();
        $display("test %s finished with %0d errors", test_name,
                 error_count - test_errors_at_start);
    endtask

    task automatic drive_idle();
        valid = 1'b0;
        read = 1'b0;
        write = 1'b0;
        width = `RV32_MEM_WIDTH_WORD;
        zero_extend = 1'b0;
        branch_op = `RV32_BRANCH_OP_NEVER;
        branch_predicted_taken = 1'b0;
        alu_non_zero = 1'b0;
        rd = 5'd0;
        rd_write = 1'b0;
        result = 32'd0;
        rs2_value = 32'd0;
        branch_pc = 32'd0;
        stall = 1'b0;
        flush = 1'b0;
    endtask

    task automatic drive_store(logic [31:0] addr, logic [1:0] wd, logic [31:0] value);
        drive_idle();
        valid = 1'b1;
        write = 1'b1;
        width = wd;
        result = addr;
        rs2_value = value;
    endtask

    task automatic drive_load(logic [31:0] addr, logic [1:0] wd, logic zx);
        logic [31:0] r;
        r = rand32();
        drive_idle();
        valid = 1'b1;
        read = 1'b1;
        width = wd;
        zero_extend = zx;
        result = addr;
        rd = r[4:0];
        rd_write = 1'b1;
    endtask

    // one instruction slot: branch check mid cycle, model update, writeback check after the edge
    task automatic run_cycle();
        logic                            taken;
        logic                            exp_mis;
        logic [`RV32_DRAM_ADDR_BITS-1:0] idx;
        mem_word_u                       word;
        #3;
        case (branch_op)
            `RV32_BRANCH_OP_ZERO:     taken = !alu_non_zero;
            `RV32_BRANCH_OP_NON_ZERO: taken = alu_non_zero;
            `RV32_BRANCH_OP_ALWAYS:   taken = 1'b1;
            default:                  taken = 1'b0;
        endcase
        exp_mis = valid && !flush && (taken != branch_predicted_taken);
        check_bit("branch_mispredicted", exp_mis, branch_mispredicted);
        check_word("redirect_pc", branch_pc, redirect_pc);
        idx = result[`RV32_DRAM_ADDR_BITS+1:2];
        word = shadow[idx];
        if (!reset_) begin
            exp_wb_valid = 1'b0;
            exp_wb_rd = 5'd0;
            exp_wb_rd_write = 1'b0;
            exp_wb_value = 32'd0;
        end else if (!stall) begin
            exp_wb_valid = valid && !flush;
            exp_wb_rd = rd;
            exp_wb_rd_write = rd_write && !flush;
            exp_wb_value = read ? extend_load(word, result[1:0], width, zero_extend) : result;
        end
        if (valid && write && !stall && !flush) begin
            shadow[idx] = merge_store(word, result[1:0], width, rs2_value);
        end
        @(posedge clk);
        #1;
        check_bit("wb_valid", exp_wb_valid, wb_valid);
        check_rd("wb_rd", exp_wb_rd, wb_rd);
        check_bit("wb_rd_write", exp_wb_rd_write, wb_rd_write);
        check_word("wb_rd_value", exp_wb_value, wb_rd_value);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] r;
        logic [1:0]  wd;
        for (int i = 0; i < `RV32_DRAM_WORDS; i++) begin
            shadow[i] = '0;  // matches the ram's initial fill
        end
        reset_ = 1'b0;
        drive_idle();

        start_test("reset");
        for (int i = 0; i < RESET_CYCLES; i++) begin
            run_cycle();
        end
        reset_ = 1'b1;
        end_test();

        start_test("word_round_trip");
        for (int i = 0; i < N_WORD; i++) begin
            a = rand_addr(`RV32_MEM_WIDTH_WORD);
            addr_q.push_back(a);
            drive_store(a, `RV32_MEM_WIDTH_WORD, rand32());
            run_cycle();
        end
        foreach (addr_q[i]) begin
            drive_load(addr_q[i], `RV32_MEM_WIDTH_WORD, 1'b0);
            run_cycle();
        end
        end_test();

        start_test("partial_stores");
        for (int i = 0; i < N_PART; i++) begin
            r = rand32();
            wd = r[0] ? `RV32_MEM_WIDTH_HALF : `RV32_MEM_WIDTH_BYTE;
            a = rand_addr(wd);
            drive_store({a[31:2], 2'b00}, `RV32_MEM_WIDTH_WORD, rand32());  // known base word
            run_cycle();
            drive_store(a, wd, rand32());
            run_cycle();
            drive_load({a[31:2], 2'b00}, `RV32_MEM_WIDTH_WORD, 1'b0);
            run_cycle();
        end
        end_test();

        start_test("load_extension");
        for (int i = 0; i < N_EXT; i++) begin
            r = rand32();
            wd = r[0] ? `RV32_MEM_WIDTH_HALF : `RV32_MEM_WIDTH_BYTE;
            drive_load(rand_addr(wd), wd, r[1]);
            run_cycle();
        end
        end_test();

        start_test("non_memory_writeback");
        for (int i = 0; i < N_ALU; i++) begin
            r = rand32();
            drive_idle();
            valid = r[0] | r[1];
            rd = r[6:2];
            rd_write = r[7];
            width = rand_width();
            result = rand32();
            run_cycle();
        end
        end_test();

        start_test("branch_resolution");
        for (int i = 0; i < N_BR; i++) begin
            r = rand32();
            drive_idle();
            valid = r[0] | r[1];
            flush = r[2] & r[3];
            branch_op = r[5:4];
            branch_predicted_taken = r[6];
            alu_non_zero = r[7];
            rd = r[12:8];
            rd_write = r[13];
            result = rand32();
            branch_pc = rand32();
            run_cycle();
        end
        end_test();

        start_test("hazards");
        for (int i = 0; i < N_HAZ; i++) begin
            r = rand32();
            wd = rand_width();
            a = rand_addr(wd);
            case (r[1:0])
                2'd0:    drive_store(a, wd, rand32());
                2'd1:    drive_load(a, wd, r[8]);
                default: begin
                    drive_idle();
                    result = rand32();
                    rd = r[13:9];
                end
            endcase
            valid = r[2] | r[3];
            stall = r[4] & r[5];
            flush = r[6] & r[7];
            rd_write = r[14];
            branch_op = r[16:15];
            branch_predicted_taken = r[17];
            alu_non_zero = r[18];
            branch_pc = rand32();
            run_cycle();
        end
        for (int i = 0; i < `RV32_DRAM_WORDS; i++) begin  // sweep confirms blocked stores
            a = i << 2;
            drive_load(a, `RV32_MEM_WIDTH_WORD, 1'b0);
            run_cycle();
        end
        end_test();

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rv32_mem_subsys.f
+incdir+.
rv32_pkg.sv
rv32_branch_unit.sv
rv32_store_align.sv
rv32_load_extract.sv
rv32_mem.sv
rv32_data_ram.sv
rv32_mem_subsys.sv
rv32_mem_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the memory stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module rv32_mem_subsys_tb \
    -f rv32_mem_subsys.f \
    -o rv32_mem_subsys_sim \
    && ./obj_dir/rv32_mem_subsys_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "^Done: no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
